/* wf_sin_table.hex */
// one sine period in 32 steps, amplitude 2047, 12-bit two's complement per line
000
18F
30F
471
5A7
6A6
763
7D8
7FF
7D8
763
6A6
5A7
471
30F
18F
000
E71
CF1
B8F
A59
95A
89D
828
801
828
89D
95A
A59
B8F
CF1
E71

/* all.f */
+incdir+include
hw/wf_pkg.sv
hw/wf_nco_mixer.sv
hw/wf_cic_decim.sv
hw/wf_sample_buffer.sv
hw/wf_readout.sv
hw/wf_sampler_top.sv
verification/wf_sampler_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= wf_sampler_tb
RTL_TOP   ?= wf_sampler_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* include/wf_tb_model.svh */
/*
 * reference model for the waterfall sampler testbench
 * - oscillator and mixer replay over the stimulus log
 * - two-stage CIC replay with exact integer arithmetic
 * - buffer keep rule for one-shot and continuous modes
 */

`ifndef WF_TB_MODEL_SVH
`define WF_TB_MODEL_SVH

// signed table word, any index wraps over one period
function automatic int table_word(int idx);
    return int'($signed(sin_tab[idx % SIN_DEPTH]));
endfunction

// product scaled back by the table amplitude, floor rounding
function automatic int scaled_product(int x, int w);
    return (x * w) >>> (SIN_BITS - 1);
endfunction

// replays every logged edge and collects the decimated I/Q pairs in order
function automatic void model_run();
    logic [PHASE_BITS-1:0] phase;
    logic [PHASE_BITS-1:0] inc_r;
    int                    ph_idx[$];
    int                    mi[$];
    int                    mq[$];
    longint                i1[2];
    longint                i2[2];
    longint                d0[2];
    longint                d1[2];
    longint                x[2];
    longint                c0;
    longint                c1;
    longint                val;
    int                    decim;
    int                    cnt;
    bit                    wrap;
    phase = '0;
    inc_r = '0;
    decim = 0;
    cnt   = 0;
    exp_i.delete();
    exp_q.delete();
    for (int c = 0; c < 2; c++)
    begin
        i1[c] = 0;
        i2[c] = 0;
        d0[c] = 0;
        d1[c] = 0;
    end
    // table index in use before each edge
    for (int n = 0; n < adc_log.size(); n++)
    begin
        ph_idx.push_back(int'(phase[PHASE_BITS-1 -: SIN_DEPTH_LOG2]));
        phase = phase + inc_r;
        if (sf_log[n])
            inc_r = inc_log[n];
    end
    // mixer output seen by the filter lags the sample by two edges
    for (int n = 0; n < adc_log.size(); n++)
    begin
        if (n < 2)
        begin
            mi.push_back(0);
            mq.push_back(0);
        end
        else
        begin
            mi.push_back(scaled_product(adc_log[n-2], table_word(ph_idx[n-2] + SIN_DEPTH / 4)));
            mq.push_back(scaled_product(-adc_log[n-2], table_word(ph_idx[n-2])));
        end
    end
    for (int n = 0; n < adc_log.size(); n++)
    begin
        x[0] = longint'(mi[n]);
        x[1] = longint'(mq[n]);
        if (sd_log[n])
        begin
            // new rate starts from an empty filter
            decim = code_log[n];
            cnt   = 0;
            for (int c = 0; c < 2; c++)
            begin
                i1[c] = 0;
                i2[c] = 0;
                d0[c] = 0;
                d1[c] = 0;
            end
        end
        else
        begin
            wrap = (cnt == (1 << decim) - 1);
            for (int c = 0; c < 2; c++)
            begin
                if (wrap)
                begin
                    c0 = i2[c] - d0[c];
                    c1 = c0 - d1[c];
                    val = c1 >>> (2 * decim);
                    if (c == 0)
                        exp_i.push_back(int'(val[15:0]));
                    else
                        exp_q.push_back(int'(val[15:0]));
                    d0[c] = i2[c];
                    d1[c] = c0;
                end
                i2[c] = i2[c] + i1[c];
                i1[c] = i1[c] + x[c];
            end
            cnt = wrap ? 0 : cnt + 1;
        end
    end
endfunction

// one-shot keeps the first entries, continuous the newest
function automatic void apply_buffer_rule(bit cont);
    while (exp_i.size() > BUF_DEPTH)
    begin
        if (cont)
        begin
            void'(exp_i.pop_front());
            void'(exp_q.pop_front());
        end
        else
        begin
            void'(exp_i.pop_back());
            void'(exp_q.pop_back());
        end
    end
endfunction

`endif

/* verification/wf_sampler_tb.sv */
/*
 * testbench for the waterfall sampler top level
 * - clock, reset, logged stimulus and four-phase host reads
 * - handshake monitor and cycle-limit timeout
 */

`timescale 1ns/1ps

module wf_sampler_tb
    import wf_pkg::*;
();

    // stimulus cycles of all tests plus reset and pause overhead
    localparam int STIM_CYCLES    = 200 + 800 + 400 + 700 + 300 + 200 + 200;
    // about six cycles per half-word read and two halves for each of 1024 entries
    localparam int READ_CYCLES    = 12 * 1024;
    localparam int TIMEOUT_CYCLES = 2 * (STIM_CYCLES + READ_CYCLES);

    logic                       adc_clk;
    logic                       rst_wf_sampler_A;
    logic signed [ADC_BITS-1:0] adc_data_i;
    logic [PHASE_BITS-1:0]      phase_inc_i;
    logic                       set_freq_i;
    logic [DECIM_LOG2_BITS-1:0] decim_log2_i;
    logic                       set_decim_i;
    logic                       continuous_i;
    logic                       rd_req_i;
    logic                       rd_sel_q_i;
    logic [SAMP_BITS-1:0]       rd_data_o;
    logic                       rd_ack_o;
    logic [COUNT_BITS-1:0]      samp_count_o;

    // stimulus log with one entry per edge after reset
    logic [SIN_BITS-1:0]   sin_tab [SIN_DEPTH];
    int                    adc_log[$];
    bit                    sf_log[$];
    logic [PHASE_BITS-1:0] inc_log[$];
    bit                    sd_log[$];
    int                    code_log[$];
    int                    exp_i[$];
    int                    exp_q[$];
    int                    mismatch_cnt;
    int                    fail_cnt;
    int                    cycle_cnt;
    logic                  ack_prev;
    logic                  req_prev;
    logic [COUNT_BITS-1:0] count_prev;
    logic [SAMP_BITS-1:0]  data_prev;

    `include "wf_tb_model.svh"

    wf_sampler_top i_dut (
        .adc_clk          (adc_clk),
        .rst_wf_sampler_A (rst_wf_sampler_A),
        .adc_data_i       (adc_data_i),
        .phase_inc_i      (phase_inc_i),
        .set_freq_i       (set_freq_i),
        .decim_log2_i     (decim_log2_i),
        .set_decim_i      (set_decim_i),
        .continuous_i     (continuous_i),
        .rd_req_i         (rd_req_i),
        .rd_sel_q_i       (rd_sel_q_i),
        .rd_data_o        (rd_data_o),
        .rd_ack_o         (rd_ack_o),
        .samp_count_o     (samp_count_o)
    );

    initial
    begin
        adc_clk = 1'b0;
    end

    always #10 adc_clk = ~adc_clk;

    always @(posedge adc_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    // handshake rules checked halfway through each cycle
    always @(negedge adc_clk)
    begin
        if (!rst_wf_sampler_A)
        begin
            if (rd_ack_o && !ack_prev)
                assert (req_prev && count_prev != 0) else
                begin
                    fail_cnt++;
                    $display("Handshake error: ack rose without a request to a filled buffer");
                end
            if (!rd_ack_o && ack_prev)
                assert (!req_prev) else
                begin
                    fail_cnt++;
                    $display("Handshake error: ack dropped while the request was still high");
                end
            if (rd_ack_o && ack_prev)
                assert (rd_data_o == data_prev) else
                begin
                    fail_cnt++;
                    $display("Handshake error: read data changed while ack was high");
                end
        end
        ack_prev   = rst_wf_sampler_A ? 1'b0 : rd_ack_o;
        req_prev   = rd_req_i;
        count_prev = samp_count_o;
        data_prev  = rd_data_o;
    end

    // inputs change a short delay after the rising edge
    task automatic next_cycle();
        @(posedge adc_clk);
        #2;
    endtask

    task automatic reset_dut(bit cont);
        rst_wf_sampler_A = 1'b1;
        continuous_i     = cont;
        adc_data_i       = '0;
        set_freq_i       = 1'b0;
        set_decim_i      = 1'b0;
        rd_req_i         = 1'b0;
        rd_sel_q_i       = 1'b0;
        repeat (4) next_cycle();
        rst_wf_sampler_A = 1'b0;
        adc_log.delete();
        sf_log.delete();
        inc_log.delete();
        sd_log.delete();
        code_log.delete();
        assert (!rd_ack_o && samp_count_o == 0) else
        begin
            fail_cnt++;
            $display("Reset error: ack high or buffer not empty after reset");
        end
    endtask

    // one logged cycle of ADC data and configuration
    task automatic drive_cycle(int adc, bit sf, logic [PHASE_BITS-1:0] inc, bit sd, int code);
        adc_data_i   = ADC_BITS'(adc);
        set_freq_i   = sf;
        phase_inc_i  = inc;
        set_decim_i  = sd;
        decim_log2_i = DECIM_LOG2_BITS'(code);
        adc_log.push_back(adc);
        sf_log.push_back(sf);
        inc_log.push_back(inc);
        sd_log.push_back(sd);
        code_log.push_back(code);
        next_cycle();
    endtask

    // first cycle strobes both settings and later cycles carry plain samples
    task automatic feed(int n, bit rnd, int dc, logic [PHASE_BITS-1:0] inc, int code);
        int adc;
        for (int k = 0; k < n; k++)
        begin
            adc = rnd ? int'($urandom_range(4095)) - 2048 : dc;
            drive_cycle(adc, k == 0, inc, k == 0, code);
        end
        set_freq_i  = 1'b0;
        set_decim_i = 1'b0;
    endtask

    // strobe held high keeps the filter cleared and stops writes
    task automatic pause_filter();
        adc_data_i  = '0;
        set_decim_i = 1'b1;
        repeat (3) next_cycle();
    endtask

    task automatic read_half(bit sel_q, output logic [SAMP_BITS-1:0] data);
        rd_sel_q_i = sel_q;
        rd_req_i   = 1'b1;
        next_cycle();
        while (!rd_ack_o)
            next_cycle();
        data     = rd_data_o;
        rd_req_i = 1'b0;
        next_cycle();
        while (rd_ack_o)
            next_cycle();
    endtask

    task automatic check_buffer(string name, bit cont);
        logic [SAMP_BITS-1:0] got;
        model_run();
        apply_buffer_rule(cont);
        assert (int'(samp_count_o) == exp_i.size()) else
        begin
            mismatch_cnt++;
            $display("Mismatch %s level: expected %0d actual %0d",
                     name, exp_i.size(), samp_count_o);
        end
        for (int k = 0; k < exp_i.size(); k++)
        begin
            read_half(1'b0, got);
            assert (int'(got) == exp_i[k]) else
            begin
                mismatch_cnt++;
                $display("Mismatch %s entry %0d I: expected %04h actual %04h",
                         name, k, exp_i[k], got);
            end
            read_half(1'b1, got);
            assert (int'(got) == exp_q[k]) else
            begin
                mismatch_cnt++;
                $display("Mismatch %s entry %0d Q: expected %04h actual %04h",
                         name, k, exp_q[k], got);
            end
        end
    endtask

    task automatic handshake_test();
        logic [SAMP_BITS-1:0] first;
        logic [SAMP_BITS-1:0] got;
        reset_dut(1'b0);
        rd_req_i = 1'b1;
        // filter held clear, so the I request waits on an empty buffer
        for (int k = 0; k < 10; k++)
            drive_cycle(0, k == 0, 32'h0600_0000, 1'b1, 1);
        assert (!rd_ack_o && samp_count_o == 0) else
        begin
            fail_cnt++;
            $display("Handshake error: request to an empty buffer was acked");
        end
        // let the filter write until the waiting request is served
        while (!rd_ack_o)
            drive_cycle(int'($urandom_range(4095)) - 2048, 1'b0, 32'h0600_0000, 1'b0, 1);
        first    = rd_data_o;
        rd_req_i = 1'b0;
        // more entries with random values behind the first one
        repeat (40)
            drive_cycle(int'($urandom_range(4095)) - 2048, 1'b0, 32'h0600_0000, 1'b0, 1);
        pause_filter();
        model_run();
        assert (int'(first) == exp_i[0]) else
        begin
            mismatch_cnt++;
            $display("Mismatch handshake waiting I: expected %04h actual %04h", exp_i[0], first);
        end
        assert (int'(samp_count_o) == exp_i.size()) else
        begin
            mismatch_cnt++;
            $display("Mismatch handshake level: expected %0d actual %0d",
                     exp_i.size(), samp_count_o);
        end
        // every entry is read as I, I again, then Q
        for (int k = 0; k < exp_i.size(); k++)
        begin
            for (int r = 0; r < 2; r++)
            begin
                read_half(1'b0, got);
                assert (int'(got) == exp_i[k]) else
                begin
                    mismatch_cnt++;
                    $display("Mismatch handshake entry %0d I read %0d: expected %04h actual %04h",
                             k, r, exp_i[k], got);
                end
            end
            assert (int'(samp_count_o) == exp_i.size() - k) else
            begin
                mismatch_cnt++;
                $display("Mismatch handshake I no pop: expected %0d actual %0d",
                         exp_i.size() - k, samp_count_o);
            end
            read_half(1'b1, got);
            assert (int'(got) == exp_q[k]) else
            begin
                mismatch_cnt++;
                $display("Mismatch handshake entry %0d Q: expected %04h actual %04h",
                         k, exp_q[k], got);
            end
            repeat (2) next_cycle();
            assert (int'(samp_count_o) == exp_i.size() - k - 1) else
            begin
                mismatch_cnt++;
                $display("Mismatch handshake Q pop: expected %0d actual %0d",
                         exp_i.size() - k - 1, samp_count_o);
            end
        end
    endtask

    initial
    begin
        void'($urandom(5839));
        $readmemh(SIN_FILE, sin_tab);
        mismatch_cnt     = 0;
        fail_cnt         = 0;
        cycle_cnt        = 0;
        rst_wf_sampler_A = 1'b1;
        adc_data_i       = '0;
        phase_inc_i      = '0;
        set_freq_i       = 1'b0;
        decim_log2_i     = '0;
        set_decim_i      = 1'b0;
        continuous_i     = 1'b0;
        rd_req_i         = 1'b0;
        rd_sel_q_i       = 1'b0;

        reset_dut(1'b0);
        feed(200, 1'b0, 1000, 32'h0, 2);
        pause_filter();
        check_buffer("dc_input", 1'b0);

        reset_dut(1'b0);
        feed(800, 1'b1, 0, 32'h0A3D_70A4, 4);
        pause_filter();
        check_buffer("random_mix", 1'b0);

        reset_dut(1'b0);
        feed(400, 1'b1, 0, 32'h1234_5678, 0);
        pause_filter();
        check_buffer("one_shot_fill", 1'b0);

        reset_dut(1'b1);
        feed(700, 1'b1, 0, 32'h0321_0FED, 1);
        pause_filter();
        check_buffer("continuous", 1'b1);

        handshake_test();

        // rate change in mid run restarts the filter
        reset_dut(1'b0);
        feed(300, 1'b1, 0, 32'h0800_0000, 3);
        feed(200, 1'b1, 0, 32'h0800_0000, 1);
        pause_filter();
        check_buffer("decim_change", 1'b0);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* hw/wf_sampler_top.sv */
/*
 * waterfall sampler top level
 * - oscillator/mixer and CIC decimator as producer
 * - sample buffer and host readout as consumer
 */

`timescale 1ns/1ps

module wf_sampler_top
    import wf_pkg::*;
(
    input  logic                       adc_clk,
    input  logic                       rst_wf_sampler_A,
    input  logic signed [ADC_BITS-1:0] adc_data_i,
    input  logic [PHASE_BITS-1:0]      phase_inc_i,
    input  logic                       set_freq_i,
    input  logic [DECIM_LOG2_BITS-1:0] decim_log2_i,
    input  logic                       set_decim_i,
    input  logic                       continuous_i,
    input  logic                       rd_req_i,
    input  logic                       rd_sel_q_i,
    output logic [SAMP_BITS-1:0]       rd_data_o,
    output logic                       rd_ack_o,
    output logic [COUNT_BITS-1:0]      samp_count_o
);

    // baseband I/Q at the ADC rate
    logic signed [MIX_BITS-1:0] mix_i;
    logic signed [MIX_BITS-1:0] mix_q;
    // decimated pairs
    logic                       cic_valid;
    wf_iq_word_u                cic_word;
    // buffer to readout
    logic                       pop;
    logic                       buf_empty;
    wf_iq_word_u                buf_word;

    wf_nco_mixer i_mixer (
        .adc_clk          (adc_clk),
        .rst_wf_sampler_A (rst_wf_sampler_A),
        .adc_data_i       (adc_data_i),
        .phase_inc_i      (phase_inc_i),
        .set_freq_i       (set_freq_i),
        .mix_i_o          (mix_i),
        .mix_q_o          (mix_q)
    );

    wf_cic_decim i_cic (
        .adc_clk          (adc_clk),
        .rst_wf_sampler_A (rst_wf_sampler_A),
        .mix_i_i          (mix_i),
        .mix_q_i          (mix_q),
        .decim_log2_i     (decim_log2_i),
        .set_decim_i      (set_decim_i),
        .cic_valid_o      (cic_valid),
        .cic_word_o       (cic_word)
    );

    wf_sample_buffer i_buffer (
        .adc_clk          (adc_clk),
        .rst_wf_sampler_A (rst_wf_sampler_A),
        .continuous_i     (continuous_i),
        .wr_i             (cic_valid),
        .wr_word_i        (cic_word),
        .pop_i            (pop),
        .rd_word_o        (buf_word),
        .empty_o          (buf_empty),
        .count_o          (samp_count_o)
    );

    wf_readout i_readout (
        .adc_clk          (adc_clk),
        .rst_wf_sampler_A (rst_wf_sampler_A),
        .rd_req_i         (rd_req_i),
        .rd_sel_q_i       (rd_sel_q_i),
        .buf_word_i       (buf_word),
        .buf_empty_i      (buf_empty),
        .rd_data_o        (rd_data_o),
        .rd_ack_o         (rd_ack_o),
        .pop_o            (pop)
    );

endmodule

/* hw/wf_readout.sv */
/*
 * four-phase req/ack host readout
 * - idle, acked and release states
 * - I or Q half picked through the union half-word view
 * - pop after a completed Q read
 */

`timescale 1ns/1ps

module wf_readout
    import wf_pkg::*;
(
    input  logic                 adc_clk,
    input  logic                 rst_wf_sampler_A,
    input  logic                 rd_req_i,
    input  logic                 rd_sel_q_i,
    input  wf_iq_word_u          buf_word_i,
    input  logic                 buf_empty_i,
    output logic [SAMP_BITS-1:0] rd_data_o,
    output logic                 rd_ack_o,
    output logic                 pop_o
);

    logic [1:0] state_r;
    logic       sel_q_r;
    logic       accept;

    // a request to an empty buffer waits in idle
    assign accept = (state_r == RD_IDLE) && rd_req_i && !buf_empty_i;

    always_ff @(posedge adc_clk)
    begin
        if (rst_wf_sampler_A)
        begin
            state_r <= RD_IDLE;
            sel_q_r <= 1'b0;
        end
        else
        begin
            case (state_r)
                RD_IDLE:
                begin
                    if (accept)
                    begin
                        state_r <= RD_ACKED;
                        sel_q_r <= rd_sel_q_i;
                    end
                end
                // ack holds until the host drops the request
                RD_ACKED:
                begin
                    if (!rd_req_i)
                        state_r <= RD_RELEASE;
                end
                default:
                    state_r <= RD_IDLE;
            endcase
        end
    end

    // data is frozen for the whole ack phase
    // half[1] is I and half[0] is Q
    always_ff @(posedge adc_clk)
    begin
        if (accept)
            rd_data_o <= buf_word_i.half[~rd_sel_q_i];
    end

    assign rd_ack_o = (state_r == RD_ACKED);
    // Q read retires the entry, I read leaves it in place
    assign pop_o    = (state_r == RD_RELEASE) && sel_q_r;

endmodule

/* hw/wf_sample_buffer.sv */
/*
 * 256-entry I/Q sample buffer
 * - one-shot mode stops writing when full
 * - continuous mode overwrites the oldest entry
 * - registered oldest entry for the reader, with write bypass
 */

`timescale 1ns/1ps

module wf_sample_buffer
    import wf_pkg::*;
(
    input  logic                  adc_clk,
    input  logic                  rst_wf_sampler_A,
    input  logic                  continuous_i,
    input  logic                  wr_i,
    input  wf_iq_word_u           wr_word_i,
    input  logic                  pop_i,
    output wf_iq_word_u           rd_word_o,
    output logic                  empty_o,
    output logic [COUNT_BITS-1:0] count_o
);

    wf_iq_word_u                 mem [BUF_DEPTH];
    logic                        continuous_r;
    logic [BUF_DEPTH_LOG2-1:0]   wr_ptr_r;
    logic [BUF_DEPTH_LOG2-1:0]   rd_ptr_r;
    logic [BUF_DEPTH_LOG2-1:0]   rd_ptr_nxt;
    logic                        full;
    logic                        do_wr;
    logic                        do_pop;
    logic                        overwrite;
    logic                        grow;

    // write mode is picked up while reset is held
    always_ff @(posedge adc_clk)
    begin
        if (rst_wf_sampler_A)
            continuous_r <= continuous_i;
    end

    always_comb
    begin
        full      = count_o[COUNT_BITS-1];
        empty_o   = (count_o == '0);
        do_pop    = pop_i && !empty_o;
        do_wr     = wr_i && (!full || continuous_r);
        // full in continuous mode, the new word replaces the oldest
        overwrite = do_wr && full && !do_pop;
        grow      = do_wr && !overwrite;
        rd_ptr_nxt = (do_pop || overwrite) ? rd_ptr_r + 1'b1 : rd_ptr_r;
    end

    always_ff @(posedge adc_clk)
    begin
        if (rst_wf_sampler_A)
        begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_o  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr_r <= wr_ptr_r + 1'b1;
            rd_ptr_r <= rd_ptr_nxt;
            if (grow && !do_pop)
                count_o <= count_o + 1'b1;
            else if (do_pop && !grow)
                count_o <= count_o - 1'b1;
        end
    end

    always_ff @(posedge adc_clk)
    begin
        if (do_wr)
            mem[wr_ptr_r] <= wr_word_i;
        // oldest entry for the next cycle, the word being written if it lands there
        if (do_wr && (wr_ptr_r == rd_ptr_nxt))
            rd_word_o <= wr_word_i;
        else
            rd_word_o <= mem[rd_ptr_nxt];
    end

endmodule

/* hw/wf_cic_decim.sv */
/*
 * two-stage CIC decimator for the I and Q channels
 * - integrators every cycle, decimation by 2^code, code 0 to 6
 * - comb stages at each counter wrap
 * - gain compensation by an arithmetic shift of stages * code
 */

`timescale 1ns/1ps

module wf_cic_decim
    import wf_pkg::*;
(
    input  logic                             adc_clk,
    input  logic                             rst_wf_sampler_A,
    input  logic signed [MIX_BITS-1:0]       mix_i_i,
    input  logic signed [MIX_BITS-1:0]       mix_q_i,
    input  logic [DECIM_LOG2_BITS-1:0]       decim_log2_i,
    input  logic                             set_decim_i,
    output logic                             cic_valid_o,
    output wf_iq_word_u                      cic_word_o
);

    // index 0 is the I channel, index 1 the Q channel
    logic [DECIM_LOG2_BITS-1:0]      decim_r;
    logic [MAX_DECIM_LOG2-1:0]       cnt_r;
    logic [MAX_DECIM_LOG2:0]         period;
    logic                            wrap;
    logic signed [CIC_ACC_BITS-1:0]  x_ext [2];
    logic signed [CIC_ACC_BITS-1:0]  integ_r [2][CIC_STAGES];
    logic signed [CIC_ACC_BITS-1:0]  comb_dly_r [2][CIC_STAGES];
    logic signed [CIC_ACC_BITS-1:0]  comb [2][CIC_STAGES];
    logic signed [CIC_ACC_BITS-1:0]  norm [2];

    always_comb
    begin
        period = (MAX_DECIM_LOG2 + 1)'(1) << decim_r;
        // last input of each decimation block
        wrap   = ({1'b0, cnt_r} == period - 1'b1);
        x_ext[0] = {{(CIC_ACC_BITS - MIX_BITS){mix_i_i[MIX_BITS-1]}}, mix_i_i};
        x_ext[1] = {{(CIC_ACC_BITS - MIX_BITS){mix_q_i[MIX_BITS-1]}}, mix_q_i};
        for (int c = 0; c < 2; c++)
        begin
            // comb chain fed from the last integrator
            comb[c][0] = integ_r[c][CIC_STAGES-1] - comb_dly_r[c][0];
            for (int s = 1; s < CIC_STAGES; s++)
                comb[c][s] = comb[c][s-1] - comb_dly_r[c][s];
            // DC gain is R^stages, undone by the shift
            norm[c] = comb[c][CIC_STAGES-1] >>> (CIC_STAGES * decim_r);
        end
    end

    // a decimation change restarts the filter from zero
    always_ff @(posedge adc_clk)
    begin
        if (rst_wf_sampler_A || set_decim_i)
        begin
            decim_r     <= rst_wf_sampler_A ? '0 : decim_log2_i;
            cnt_r       <= '0;
            cic_valid_o <= 1'b0;
            for (int c = 0; c < 2; c++)
            begin
                for (int s = 0; s < CIC_STAGES; s++)
                begin
                    integ_r[c][s]    <= '0;
                    comb_dly_r[c][s] <= '0;
                end
            end
        end
        else
        begin
            cnt_r       <= wrap ? '0 : cnt_r + 1'b1;
            cic_valid_o <= wrap;
            for (int c = 0; c < 2; c++)
            begin
                integ_r[c][0] <= integ_r[c][0] + x_ext[c];
                for (int s = 1; s < CIC_STAGES; s++)
                    integ_r[c][s] <= integ_r[c][s] + integ_r[c][s-1];
                // comb delays advance at the decimated rate only
                if (wrap)
                begin
                    comb_dly_r[c][0] <= integ_r[c][CIC_STAGES-1];
                    for (int s = 1; s < CIC_STAGES; s++)
                        comb_dly_r[c][s] <= comb[c][s-1];
                end
            end
        end
    end

    // output word lines up with the valid pulse
    always_ff @(posedge adc_clk)
    begin
        if (wrap)
        begin
            cic_word_o.iq.i <= norm[0][SAMP_BITS-1:0];
            cic_word_o.iq.q <= norm[1][SAMP_BITS-1:0];
        end
    end

endmodule

/* hw/wf_nco_mixer.sv */
/*
 * phase accumulator oscillator and I/Q mixer
 * - latched phase increment, 32-bit phase
 * - sine table lookup with cosine at a quarter-period offset
 * - registered products scaled back to the mixer width
 */

`timescale 1ns/1ps

module wf_nco_mixer
    import wf_pkg::*;
(
    input  logic                       adc_clk,
    input  logic                       rst_wf_sampler_A,
    input  logic signed [ADC_BITS-1:0] adc_data_i,
    input  logic [PHASE_BITS-1:0]      phase_inc_i,
    input  logic                       set_freq_i,
    output logic signed [MIX_BITS-1:0] mix_i_o,
    output logic signed [MIX_BITS-1:0] mix_q_o
);

    logic [PHASE_BITS-1:0]        phase_inc_r;
    logic [PHASE_BITS-1:0]        phase_r;
    logic signed [SIN_BITS-1:0]   sin_rom [SIN_DEPTH];
    logic [SIN_DEPTH_LOG2-1:0]    sin_idx;
    logic signed [ADC_BITS-1:0]   adc_r;
    logic signed [SIN_BITS-1:0]   sin_r;
    logic signed [SIN_BITS-1:0]   cos_r;
    logic signed [PROD_BITS-1:0]  prod_i;
    logic signed [PROD_BITS-1:0]  prod_q;

    initial
    begin
        $readmemh(SIN_FILE, sin_rom);
    end

    // new increment is used from the cycle after the strobe
    always_ff @(posedge adc_clk)
    begin
        if (rst_wf_sampler_A)
        begin
            phase_inc_r <= '0;
            phase_r     <= '0;
        end
        else
        begin
            if (set_freq_i)
                phase_inc_r <= phase_inc_i;
            phase_r <= phase_r + phase_inc_r;
        end
    end

    // top phase bits address the table
    assign sin_idx = phase_r[PHASE_BITS-1 -: SIN_DEPTH_LOG2];

    // I = x * cos, Q = -(x * sin)
    always_comb
    begin
        prod_i = adc_r * cos_r;
        prod_q = -(adc_r * sin_r);
    end

    // stage 1 captures sample and table words, stage 2 the scaled products
    always_ff @(posedge adc_clk)
    begin
        if (rst_wf_sampler_A)
        begin
            adc_r   <= '0;
            sin_r   <= '0;
            cos_r   <= '0;
            mix_i_o <= '0;
            mix_q_o <= '0;
        end
        else
        begin
            adc_r   <= adc_data_i;
            sin_r   <= sin_rom[sin_idx];
            // index wraps modulo the table depth
            cos_r   <= sin_rom[sin_idx + COS_OFFSET];
            mix_i_o <= MIX_BITS'(prod_i >>> MIX_SHIFT);
            mix_q_o <= MIX_BITS'(prod_q >>> MIX_SHIFT);
        end
    end

endmodule

/* hw/wf_pkg.sv */
/*
 * waterfall sampler shared definitions
 * - ADC, mixer, CIC and sample widths
 * - sine table and sample buffer sizes
 * - readout handshake state codes
 * - I/Q word union with a pair view and a half-word view
 */

package wf_pkg;

    // ADC front end and mixer
    localparam int ADC_BITS       = 12;
    localparam int MIX_BITS       = 14;
    localparam int SIN_BITS       = 12;
    localparam int SIN_DEPTH_LOG2 = 5;
    localparam int SIN_DEPTH      = 1 << SIN_DEPTH_LOG2;
    localparam int PHASE_BITS     = 32;
    localparam int PROD_BITS      = ADC_BITS + SIN_BITS;
    // table amplitude is 2^(SIN_BITS-1)-1, so shift out that scale
    localparam int MIX_SHIFT      = SIN_BITS - 1;
    // quarter period between sine and cosine
    localparam logic [SIN_DEPTH_LOG2-1:0] COS_OFFSET = SIN_DEPTH_LOG2'(SIN_DEPTH / 4);
    localparam string SIN_FILE    = "wf_sin_table.hex";

    // CIC decimator
    localparam int DECIM_LOG2_BITS = 3;
    localparam int MAX_DECIM_LOG2  = 6;
    localparam int CIC_STAGES      = 2;
    // bit growth is stages * log2(R) for unit differential delay
    localparam int CIC_ACC_BITS    = MIX_BITS + CIC_STAGES * MAX_DECIM_LOG2;
    localparam int SAMP_BITS       = 16;

    // sample buffer
    localparam int BUF_DEPTH_LOG2 = 8;
    localparam int BUF_DEPTH      = 1 << BUF_DEPTH_LOG2;
    localparam int COUNT_BITS     = BUF_DEPTH_LOG2 + 1;

    // readout FSM states
    localparam logic [1:0] RD_IDLE    = 2'd0;
    localparam logic [1:0] RD_ACKED   = 2'd1;
    localparam logic [1:0] RD_RELEASE = 2'd2;

    // one buffer word seen as an I/Q pair or as two halves
    // half[1] aliases i and half[0] aliases q
    typedef union packed {
        struct packed {
            logic [SAMP_BITS-1:0] i;
            logic [SAMP_BITS-1:0] q;
        } iq;
        logic [1:0][SAMP_BITS-1:0] half;
    } wf_iq_word_u;

endpackage
